/* fpsu_pkg.sv */
// ******************************
// shared widths, opcodes and the packed
// structs passed between the stages of the
// packed-data execution unit
// ******************************
`default_nettype none

package fpsu_pkg;

  parameter int HALF_W = 16;
  parameter int DATA_W = 2 * HALF_W; // two signed halves

  typedef enum logic [2:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_RSUB, // b minus a
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL
  } op_e;

  // operand source for the forwarding mux
  typedef enum logic [1:0] {
    SRC_REG,
    SRC_ADD,
    SRC_MUL
  } src_e;

  typedef struct packed {
    logic ovf;  // signed overflow in some half
    logic zero; // whole word is 0
  } flags_t;

  typedef struct packed {
    logic              valid;
    op_e               op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } lane_op_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    flags_t            flags;
  } lane_res_t;

  typedef struct packed {
    flags_t flags;
    logic   from_add;
    logic   from_mul;
  } ret_t;

endpackage

`default_nettype wire

/* fpsu_issue.sv */
// ******************************
// issue stage: operand forwarding, opcode
// decode and one registered dispatch per lane
// ******************************
`timescale 1ns/1ns
`default_nettype none

module fpsu_issue (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              in_valid,
  input  wire fpsu_pkg::op_e               in_op,
  input  wire [fpsu_pkg::DATA_W-1:0]       in_a,
  input  wire [fpsu_pkg::DATA_W-1:0]       in_b,
  input  wire fpsu_pkg::src_e              a_sel,
  input  wire fpsu_pkg::src_e              b_sel,
  input  wire [fpsu_pkg::DATA_W-1:0]       fwd_add,
  input  wire [fpsu_pkg::DATA_W-1:0]       fwd_mul,
  output fpsu_pkg::lane_op_t               add_op,
  output fpsu_pkg::lane_op_t               mul_op
);

  logic [fpsu_pkg::DATA_W-1:0] opnd_a;
  logic [fpsu_pkg::DATA_W-1:0] opnd_b;
  logic                        to_add;
  logic                        to_mul;

  logic                        add_vld;
  logic                        mul_vld;
  fpsu_pkg::op_e               op_q;
  logic [fpsu_pkg::DATA_W-1:0] a_q;
  logic [fpsu_pkg::DATA_W-1:0] b_q;

  // pick register input or the last result of a lane
  function automatic logic [fpsu_pkg::DATA_W-1:0] fwd_pick(
    input fpsu_pkg::src_e              sel,
    input logic [fpsu_pkg::DATA_W-1:0] reg_val
  );
    case (sel)
      fpsu_pkg::SRC_ADD: return fwd_add;
      fpsu_pkg::SRC_MUL: return fwd_mul;
      default:           return reg_val;
    endcase
  endfunction

  assign opnd_a = fwd_pick(a_sel, in_a);
  assign opnd_b = fwd_pick(b_sel, in_b);

  // nop issues nothing, mul goes to its own lane
  assign to_mul = in_valid && (in_op == fpsu_pkg::OP_MUL);
  assign to_add = in_valid && (in_op != fpsu_pkg::OP_MUL) && (in_op != fpsu_pkg::OP_NOP);

  always_ff @(posedge clk) begin
    if (rst) begin
      add_vld <= 1'b0;
      mul_vld <= 1'b0;
    end else begin
      add_vld <= to_add;
      mul_vld <= to_mul;
    end
  end

  always_ff @(posedge clk) begin
    op_q <= in_op;
    a_q  <= opnd_a;
    b_q  <= opnd_b;
  end

  // both lanes see the same payload, only valid differs
  assign add_op = '{add_vld, op_q, a_q, b_q};
  assign mul_op = '{mul_vld, op_q, a_q, b_q};

  a_one_lane: assert property (@(posedge clk) disable iff (rst)
    !(add_op.valid && mul_op.valid))
    else $error("issue sent one op to both lanes");

endmodule

`default_nettype wire

/* fpsu_add_lane.sv */
// ******************************
// add lane: add, sub, reverse sub and logic
// ops per 16-bit half, one registered stage
// ******************************
`timescale 1ns/1ns
`default_nettype none

module fpsu_add_lane (
  input  wire                     clk,
  input  wire                     rst,
  input  wire fpsu_pkg::lane_op_t op_in,
  output fpsu_pkg::lane_res_t     res
);

  localparam int HW = fpsu_pkg::HALF_W;
  localparam int NH = fpsu_pkg::DATA_W / fpsu_pkg::HALF_W;

  logic [fpsu_pkg::DATA_W-1:0] arith_data;
  logic [NH-1:0]               arith_ovf;
  logic [fpsu_pkg::DATA_W-1:0] next_data;
  logic                        next_ovf;

  logic                        vld_q;
  logic [fpsu_pkg::DATA_W-1:0] data_q;
  fpsu_pkg::flags_t            flags_q;

  for (genvar h = 0; h < NH; h++) begin : g_half
    logic signed [HW:0] xa;
    logic signed [HW:0] xb;
    logic signed [HW:0] sum;

    assign xa = {op_in.a[h*HW+HW-1], op_in.a[h*HW +: HW]}; // one guard bit
    assign xb = {op_in.b[h*HW+HW-1], op_in.b[h*HW +: HW]};

    always_comb begin
      case (op_in.op)
        fpsu_pkg::OP_ADD:  sum = xa + xb;
        fpsu_pkg::OP_SUB:  sum = xa - xb;
        fpsu_pkg::OP_RSUB: sum = xb - xa;
        default:           sum = '0;
      endcase
    end

    assign arith_data[h*HW +: HW] = sum[HW-1:0]; // wraps
    assign arith_ovf[h]           = sum[HW] ^ sum[HW-1];
  end

  always_comb begin
    next_ovf = 1'b0;
    case (op_in.op)
      fpsu_pkg::OP_ADD,
      fpsu_pkg::OP_SUB,
      fpsu_pkg::OP_RSUB: begin
        next_data = arith_data;
        next_ovf  = |arith_ovf;
      end
      fpsu_pkg::OP_AND: next_data = op_in.a & op_in.b;
      fpsu_pkg::OP_OR:  next_data = op_in.a | op_in.b;
      fpsu_pkg::OP_XOR: next_data = op_in.a ^ op_in.b;
      default:          next_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) vld_q <= 1'b0;
    else     vld_q <= op_in.valid;
  end

  always_ff @(posedge clk) begin
    data_q        <= next_data;
    flags_q.ovf   <= next_ovf;
    flags_q.zero  <= (next_data == '0);
  end

  assign res = '{vld_q, data_q, flags_q};

  // issue decode must keep multiplies out of here
  a_no_mul: assert property (@(posedge clk) disable iff (rst)
    op_in.valid |-> (op_in.op != fpsu_pkg::OP_MUL))
    else $error("multiply reached the add lane");

endmodule

`default_nettype wire

/* fpsu_mul_lane.sv */
// ******************************
// multiply lane: signed 16x16 per half, low
// half kept, MUL_DEPTH deep shift pipeline
// ******************************
`timescale 1ns/1ns
`default_nettype none

module fpsu_mul_lane #(
  parameter int MUL_DEPTH = 3
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire fpsu_pkg::lane_op_t op_in,
  output fpsu_pkg::lane_res_t     res
);

  localparam int HW = fpsu_pkg::HALF_W;
  localparam int NH = fpsu_pkg::DATA_W / fpsu_pkg::HALF_W;

  logic [fpsu_pkg::DATA_W-1:0] prod_lo;
  logic [NH-1:0]               prod_ovf;

  logic [MUL_DEPTH-1:0]        vld_q;
  logic [fpsu_pkg::DATA_W-1:0] data_q  [MUL_DEPTH];
  fpsu_pkg::flags_t            flags_q [MUL_DEPTH];

  for (genvar h = 0; h < NH; h++) begin : g_half
    logic signed [2*HW-1:0] prod;

    assign prod = $signed(op_in.a[h*HW +: HW]) * $signed(op_in.b[h*HW +: HW]);
    assign prod_lo[h*HW +: HW] = prod[HW-1:0];
    // upper bits must all copy the low half's sign
    assign prod_ovf[h] = (prod[2*HW-1:HW-1] != {(HW+1){prod[HW-1]}});
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= op_in.valid;
      for (int i = 1; i < MUL_DEPTH; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    data_q[0]       <= prod_lo;
    flags_q[0].ovf  <= |prod_ovf;
    flags_q[0].zero <= (prod_lo == '0);
    for (int i = 1; i < MUL_DEPTH; i++) begin
      data_q[i]  <= data_q[i-1];
      flags_q[i] <= flags_q[i-1];
    end
  end

  assign res = '{vld_q[MUL_DEPTH-1], data_q[MUL_DEPTH-1], flags_q[MUL_DEPTH-1]};

  a_latency: assert property (@(posedge clk) disable iff (rst)
    op_in.valid |-> ##MUL_DEPTH res.valid)
    else $error("multiply result missed its slot");

endmodule

`default_nettype wire

/* fpsu_retire.sv */
// ******************************
// retire stage: merges lane flags into one
// report, keeps sticky status, raises trap
// ******************************
`timescale 1ns/1ns
`default_nettype none

module fpsu_retire (
  input  wire                      clk,
  input  wire                      rst,
  input  wire fpsu_pkg::lane_res_t add_res,
  input  wire fpsu_pkg::lane_res_t mul_res,
  input  wire fpsu_pkg::flags_t    exc_mask,
  input  wire                      status_clr,
  output logic                     ret_en,
  output fpsu_pkg::ret_t           ret,
  output fpsu_pkg::flags_t         status,
  output logic                     trap
);

  fpsu_pkg::flags_t add_fl;
  fpsu_pkg::flags_t mul_fl;
  fpsu_pkg::flags_t merged;
  logic             any_done;

  assign add_fl   = add_res.valid ? add_res.flags : '0;
  assign mul_fl   = mul_res.valid ? mul_res.flags : '0;
  assign merged   = add_fl | mul_fl; // both lanes may finish together
  assign any_done = add_res.valid | mul_res.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_en <= 1'b0;
      trap   <= 1'b0;
      status <= '0;
    end else begin
      ret_en <= any_done;
      trap   <= any_done && |(merged & ~exc_mask); // mask bit set hides flag
      // clear still picks up what retires now
      status <= (status_clr ? '0 : status) | merged;
    end
  end

  always_ff @(posedge clk) begin
    ret.flags    <= merged;
    ret.from_add <= add_res.valid;
    ret.from_mul <= mul_res.valid;
  end

  a_trap_en: assert property (@(posedge clk) disable iff (rst)
    trap |-> ret_en)
    else $error("trap without a retire");

endmodule

`default_nettype wire

/* fpsu_top.sv */
// ******************************
// top of the packed-data unit: issue, add
// lane and multiply lane, then retire
// ******************************
`timescale 1ns/1ns
`default_nettype none

module fpsu_top #(
  parameter int MUL_DEPTH = 3
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        in_valid,
  input  wire fpsu_pkg::op_e         in_op,
  input  wire [fpsu_pkg::DATA_W-1:0] in_a,
  input  wire [fpsu_pkg::DATA_W-1:0] in_b,
  input  wire fpsu_pkg::src_e        a_sel,
  input  wire fpsu_pkg::src_e        b_sel,
  input  wire fpsu_pkg::flags_t      exc_mask,
  input  wire                        status_clr,
  output fpsu_pkg::lane_res_t        res_add,
  output fpsu_pkg::lane_res_t        res_mul,
  output logic                       ret_en,
  output fpsu_pkg::ret_t             ret,
  output fpsu_pkg::flags_t           status,
  output logic                       trap
);

  fpsu_pkg::lane_op_t add_op;
  fpsu_pkg::lane_op_t mul_op;

  fpsu_issue u_issue (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_a     (in_a),
    .in_b     (in_b),
    .a_sel    (a_sel),
    .b_sel    (b_sel),
    .fwd_add  (res_add.data), // forwarding taps
    .fwd_mul  (res_mul.data),
    .add_op   (add_op),
    .mul_op   (mul_op)
  );

  fpsu_add_lane u_add (
    .clk   (clk),
    .rst   (rst),
    .op_in (add_op),
    .res   (res_add)
  );

  fpsu_mul_lane #(
    .MUL_DEPTH (MUL_DEPTH)
  ) u_mul (
    .clk   (clk),
    .rst   (rst),
    .op_in (mul_op),
    .res   (res_mul)
  );

  fpsu_retire u_retire (
    .clk        (clk),
    .rst        (rst),
    .add_res    (res_add),
    .mul_res    (res_mul),
    .exc_mask   (exc_mask),
    .status_clr (status_clr),
    .ret_en     (ret_en),
    .ret        (ret),
    .status     (status),
    .trap       (trap)
  );

endmodule

`default_nettype wire

/* tb_fpsu.sv */
// ******************************
// self-checking testbench for fpsu_top
// a cycle model feeds expected outputs to
// concurrent assertions
// ******************************
`timescale 1ns/1ns
`default_nettype none

module tb_fpsu;

  localparam int MUL_DEPTH  = 3;
  localparam int N_ADD_RAND = 40;
  localparam int N_MUL      = 16;
  localparam int N_MIX      = 24;
  localparam int TOTAL_OPS  = N_ADD_RAND + N_MUL + N_MIX + 16;
  // drains and the two resets need their own cycles
  localparam int LIMIT      = TOTAL_OPS + MUL_DEPTH + 12 * (MUL_DEPTH + 4) + 20;

  typedef struct packed {
    int                  due;
    fpsu_pkg::lane_res_t res;
  } pend_t;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  in_valid;
  fpsu_pkg::op_e         in_op;
  logic [31:0]           in_a;
  logic [31:0]           in_b;
  fpsu_pkg::src_e        a_sel;
  fpsu_pkg::src_e        b_sel;
  fpsu_pkg::flags_t      exc_mask;
  logic                  status_clr;
  fpsu_pkg::lane_res_t   res_add;
  fpsu_pkg::lane_res_t   res_mul;
  logic                  ret_en;
  fpsu_pkg::ret_t        ret;
  fpsu_pkg::flags_t      status;
  logic                  trap;

  fpsu_pkg::lane_res_t   exp_add;
  fpsu_pkg::lane_res_t   exp_mul;
  logic                  exp_ret_en;
  fpsu_pkg::ret_t        exp_ret;
  fpsu_pkg::flags_t      exp_status;
  logic                  exp_trap;
  pend_t                 add_q[$];
  pend_t                 mul_q[$];

  integer seed    = 7264;
  int     cyc     = 0;
  int     errors  = 0;
  int     issued  = 0;
  int     checked = 0;

  fpsu_top #(.MUL_DEPTH(MUL_DEPTH)) DUT (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op), .in_a(in_a),
    .in_b(in_b), .a_sel(a_sel), .b_sel(b_sel), .exc_mask(exc_mask),
    .status_clr(status_clr), .res_add(res_add), .res_mul(res_mul),
    .ret_en(ret_en), .ret(ret), .status(status), .trap(trap)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  task automatic report_mismatch(string name, logic [31:0] exp_v, logic [31:0] got_v);
    errors++;
    $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, got_v);
  endtask

  task automatic report_not_idle();
    errors++;
    $display("%0t outputs were not idle after reset", $time);
  endtask

  // per half in plain integers, range test gives ovf
  function automatic fpsu_pkg::lane_res_t model_op(fpsu_pkg::op_e op, logic [31:0] a,
                                                   logic [31:0] b);
    fpsu_pkg::lane_res_t r;
    int x;
    int y;
    int v;
    r = '0;
    r.valid = 1'b1;
    for (int h = 0; h < 2; h++) begin
      x = int'($signed(a[16*h +: 16]));
      y = int'($signed(b[16*h +: 16]));
      case (op)
        fpsu_pkg::OP_ADD:  v = x + y;
        fpsu_pkg::OP_SUB:  v = x - y;
        fpsu_pkg::OP_RSUB: v = y - x;
        fpsu_pkg::OP_AND:  v = x & y; // sign-extended, never out of range
        fpsu_pkg::OP_OR:   v = x | y;
        fpsu_pkg::OP_XOR:  v = x ^ y;
        fpsu_pkg::OP_MUL:  v = x * y;
        default:           v = 0;
      endcase
      r.data[16*h +: 16] = v[15:0];
      if (v > 32767 || v < -32768) r.flags.ovf = 1'b1;
    end
    r.flags.zero = (r.data == 32'h0);
    return r;
  endfunction

  function automatic logic [31:0] pick(fpsu_pkg::src_e sel, logic [31:0] reg_v,
                                       logic [31:0] fa, logic [31:0] fm);
    if (sel == fpsu_pkg::SRC_ADD) return fa;
    if (sel == fpsu_pkg::SRC_MUL) return fm;
    return reg_v;
  endfunction

  always @(posedge clk) begin : model
    fpsu_pkg::flags_t merged;
    logic [31:0]      opa;
    logic [31:0]      opb;
    pend_t            p;
    if (rst) begin
      exp_add    <= '0;
      exp_mul    <= '0;
      exp_ret_en <= 1'b0;
      exp_ret    <= '0;
      exp_trap   <= 1'b0;
      exp_status <= '0;
      add_q.delete();
      mul_q.delete();
    end else begin
      merged = (exp_add.valid ? exp_add.flags : 2'b00) | (exp_mul.valid ? exp_mul.flags : 2'b00);
      exp_ret_en <= exp_add.valid || exp_mul.valid;
      exp_ret    <= '{merged, exp_add.valid, exp_mul.valid};
      exp_trap   <= (exp_add.valid || exp_mul.valid) && ((merged & ~exc_mask) != 2'b00);
      exp_status <= (status_clr ? 2'b00 : exp_status) | merged;
      exp_add.valid <= 1'b0;
      exp_mul.valid <= 1'b0;
      if (add_q.size() > 0 && add_q[0].due == cyc) begin
        p = add_q.pop_front();
        exp_add <= p.res;
        checked++;
      end
      if (mul_q.size() > 0 && mul_q[0].due == cyc) begin
        p = mul_q.pop_front();
        exp_mul <= p.res;
        checked++;
      end
      if (in_valid && in_op != fpsu_pkg::OP_NOP) begin
        // forwarded operand is what the lane outputs show at this edge
        opa = pick(a_sel, in_a, res_add.data, res_mul.data);
        opb = pick(b_sel, in_b, res_add.data, res_mul.data);
        p.res = model_op(in_op, opa, opb);
        if (in_op == fpsu_pkg::OP_MUL) begin
          p.due = cyc + MUL_DEPTH;
          mul_q.push_back(p);
        end else begin
          p.due = cyc + 1;
          add_q.push_back(p);
        end
        issued++;
      end
    end
  end

  a_add_v: assert property (@(posedge clk) disable iff (rst) res_add.valid == exp_add.valid)
    else report_mismatch("res_add.valid", 32'($sampled(exp_add.valid)),
                         32'($sampled(res_add.valid)));
  a_add_d: assert property (@(posedge clk) disable iff (rst)
    res_add.valid |-> res_add.data == exp_add.data)
    else report_mismatch("res_add.data", $sampled(exp_add.data), $sampled(res_add.data));
  a_add_f: assert property (@(posedge clk) disable iff (rst)
    res_add.valid |-> res_add.flags == exp_add.flags)
    else report_mismatch("res_add.flags", 32'($sampled(exp_add.flags)),
                         32'($sampled(res_add.flags)));
  a_mul_v: assert property (@(posedge clk) disable iff (rst) res_mul.valid == exp_mul.valid)
    else report_mismatch("res_mul.valid", 32'($sampled(exp_mul.valid)),
                         32'($sampled(res_mul.valid)));
  a_mul_d: assert property (@(posedge clk) disable iff (rst)
    res_mul.valid |-> res_mul.data == exp_mul.data)
    else report_mismatch("res_mul.data", $sampled(exp_mul.data), $sampled(res_mul.data));
  a_mul_f: assert property (@(posedge clk) disable iff (rst)
    res_mul.valid |-> res_mul.flags == exp_mul.flags)
    else report_mismatch("res_mul.flags", 32'($sampled(exp_mul.flags)),
                         32'($sampled(res_mul.flags)));
  a_ret_en: assert property (@(posedge clk) disable iff (rst) ret_en == exp_ret_en)
    else report_mismatch("ret_en", 32'($sampled(exp_ret_en)), 32'($sampled(ret_en)));
  a_ret: assert property (@(posedge clk) disable iff (rst) ret_en |-> ret == exp_ret)
    else report_mismatch("ret", 32'($sampled(exp_ret)), 32'($sampled(ret)));
  a_trap: assert property (@(posedge clk) disable iff (rst) trap == exp_trap)
    else report_mismatch("trap", 32'($sampled(exp_trap)), 32'($sampled(trap)));
  a_status: assert property (@(posedge clk) disable iff (rst) status == exp_status)
    else report_mismatch("status", 32'($sampled(exp_status)), 32'($sampled(status)));
  a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
    !res_add.valid && !res_mul.valid && !ret_en && !trap && status == 2'b00)
    else report_not_idle();

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // 8-bit signed per half, products stay in range
  function automatic logic [31:0] small_word();
    logic [31:0] r;
    r = $random(seed);
    return {{8{r[7]}}, r[7:0], {8{r[15]}}, r[15:8]};
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic issue_op(fpsu_pkg::op_e op, logic [31:0] a, logic [31:0] b,
                          fpsu_pkg::src_e sa, fpsu_pkg::src_e sb);
    in_valid = 1'b1;
    in_op    = op;
    in_a     = a;
    in_b     = b;
    a_sel    = sa;
    b_sel    = sb;
    idle_cycle();
    in_valid = 1'b0;
    in_op    = fpsu_pkg::OP_NOP;
    a_sel    = fpsu_pkg::SRC_REG;
    b_sel    = fpsu_pkg::SRC_REG;
  endtask

  task automatic drain();
    while (add_q.size() != 0 || mul_q.size() != 0 || exp_add.valid || exp_mul.valid ||
           exp_ret_en) begin
      idle_cycle();
    end
    idle_cycle();
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) idle_cycle();
    rst = 1'b0;
  endtask

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_op      = fpsu_pkg::OP_NOP;
    in_a       = '0;
    in_b       = '0;
    a_sel      = fpsu_pkg::SRC_REG;
    b_sel      = fpsu_pkg::SRC_REG;
    exc_mask   = 2'b11;
    status_clr = 1'b0;
    #1;
    apply_reset();

    // add lane, random then overflow and zero corners
    for (int i = 0; i < N_ADD_RAND; i++) begin
      issue_op(fpsu_pkg::op_e'(3'(1 + rand_word() % 6)), rand_word(), rand_word(),
               fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    end
    issue_op(fpsu_pkg::OP_ADD, 32'h7fff_0001, 32'h0001_0002, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    issue_op(fpsu_pkg::OP_SUB, 32'h1234_abcd, 32'h1234_abcd, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    issue_op(fpsu_pkg::OP_RSUB, 32'h8000_0001, 32'h0001_0005, fpsu_pkg::SRC_REG,
             fpsu_pkg::SRC_REG);
    drain();

    // multiplies back to back, several in flight
    for (int i = 0; i < N_MUL; i++) begin
      issue_op(fpsu_pkg::OP_MUL, (i % 2) ? rand_word() : small_word(), small_word(),
               fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    end
    issue_op(fpsu_pkg::OP_MUL, 32'h4000_0003, 32'h0004_fffe, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    drain();

    // forwarding from each lane, taken while the result is on the output
    issue_op(fpsu_pkg::OP_ADD, 32'h0010_0020, 32'h0003_0004, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    idle_cycle();
    issue_op(fpsu_pkg::OP_SUB, 32'h0, 32'h0001_0001, fpsu_pkg::SRC_ADD, fpsu_pkg::SRC_REG);
    idle_cycle();
    issue_op(fpsu_pkg::OP_MUL, 32'h0002_0003, 32'h0, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_ADD);
    repeat (MUL_DEPTH) idle_cycle();
    issue_op(fpsu_pkg::OP_XOR, 32'h0, 32'h00ff_ff00, fpsu_pkg::SRC_MUL, fpsu_pkg::SRC_REG);
    drain();

    // mul then add later, both finish together
    exc_mask = 2'b00;
    issue_op(fpsu_pkg::OP_MUL, 32'h4000_0003, 32'h0004_fffe, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    repeat (MUL_DEPTH - 2) idle_cycle();
    issue_op(fpsu_pkg::OP_SUB, 32'h5555_5555, 32'h5555_5555, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    drain();

    // trap with ovf open, then masked
    issue_op(fpsu_pkg::OP_ADD, 32'h7fff_0001, 32'h0001_0002, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    drain();
    exc_mask = 2'b10;
    issue_op(fpsu_pkg::OP_ADD, 32'h7fff_0001, 32'h0001_0002, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    drain();

    // status clear alone, then on the edge a flag retires
    status_clr = 1'b1;
    idle_cycle();
    status_clr = 1'b0;
    issue_op(fpsu_pkg::OP_SUB, 32'h0000_0001, 32'h0000_0001, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG);
    idle_cycle();
    status_clr = 1'b1;
    idle_cycle();
    status_clr = 1'b0;
    drain();

    // mixed ops with random operand sources
    exc_mask = 2'b00;
    for (int i = 0; i < N_MIX; i++) begin
      issue_op(fpsu_pkg::op_e'(3'(rand_word() % 8)), small_word(), rand_word(),
               fpsu_pkg::src_e'(2'(rand_word() % 3)), fpsu_pkg::src_e'(2'(rand_word() % 3)));
    end
    drain();

    apply_reset(); // status was set, must read 0 again
    idle_cycle();
    drain();

    $display("ops issued %0d, results checked %0d, errors %0d", issued, checked, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fpsu_top.f */
fpsu_pkg.sv
fpsu_issue.sv
fpsu_add_lane.sv
fpsu_mul_lane.sv
fpsu_retire.sv
fpsu_top.sv
tb_fpsu.sv

/* Makefile */
# Verilator build and run for the fpsu testbench

VERILATOR ?= verilator
TOP       ?= tb_fpsu
FILELIST  ?= fpsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -qx "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
